//--- hdl/anim_settings.svh
`ifndef ANIM_SETTINGS_SVH
`define ANIM_SETTINGS_SVH

// scene size
`define NUM_DOGS        4     // dog controllers in the scene

// sprite box in pixels
`define DOG_W           32    // box width, offsets 0..31
`define DOG_H           24    // box height, offsets 0..23

// every dog starts here on launch
`define START_X         11
`define START_Y         318

// movement per frame tick
`define STEP_X          4     // horizontal step while walking or jumping
`define JUMP_STEP_Y     6     // vertical step per jump tick

// routine phase lengths
`define WALK_LOOPS_A    4     // four-frame walk loops before the sniff
`define SNIFF_ROUNDS    3     // sniff1/sniff2 pairs
`define WALK_LOOPS_B    2     // walk loops after the sniff
`define SURPRISE_TICKS  2     // ticks spent in the surprised pose
`define JUMP_TICKS      5     // ticks in each half of the jump

// launcher
`define LAUNCH_GAP      3     // frame ticks between two dog launches

`endif

//--- hdl/dogAnimPkg.sv
package dogAnimPkg;

    // dog routine states, Idle before the first launch, Hide at the end
    typedef enum logic [4:0] {
        Idle, Walk1, Walk2, Walk3, Walk4,
        Sniff1, Sniff2, Surprised,
        Jump1, Jump2, Hide
    } dogStateT;

    // frame codes, index into the sprite ROM (outside this design)
    typedef enum logic [4:0] {
        frameBlank     = 5'd0,
        frameWalk1     = 5'd1,
        frameWalk2     = 5'd2,
        frameWalk3     = 5'd3,
        frameWalk4     = 5'd4,
        frameSniff1    = 5'd5,
        frameSniff2    = 5'd6,
        frameSurprised = 5'd7,
        frameJumpUp    = 5'd8,
        frameJumpDown  = 5'd9
    } frameCodeT;

    typedef logic [1:0] dogIdxT;  // which of the four dogs

endpackage

//--- hdl/dogControl.sv
`timescale 1ns/1ps
`include "anim_settings.svh"

module dogControl import screenPkg::*, dogAnimPkg::*;
(
    input  logic       ANIM_Clk,
    input  logic       reset,
    input  logic       frameTick,
    input  logic       launch,
    output pixelCoordT dogX,
    output pixelCoordT dogY,
    output frameCodeT  frame,
    output logic       active,
    output logic       done
);

    dogStateT   state, nextState;
    logic [2:0] loopCnt;      // walk loops finished in this walk phase
    logic [2:0] sniffCnt;     // sniff pairs finished
    logic [2:0] surpriseCnt;  // ticks spent surprised
    logic [2:0] jumpCnt;      // ticks spent in current jump half
    logic       secondWalk;   // set once the sniff phase is over
    logic       launchOk;     // launch accepted in this cycle
    logic       moveX, moveUp, moveDown;
    logic       loopLast, sniffLast, surpriseLast, jumpLast;

    // frame code shown for each state
    function automatic frameCodeT frameOf(input dogStateT s);
        case (s)
            Walk1:     return frameWalk1;
            Walk2:     return frameWalk2;
            Walk3:     return frameWalk3;
            Walk4:     return frameWalk4;
            Sniff1:    return frameSniff1;
            Sniff2:    return frameSniff2;
            Surprised: return frameSurprised;
            Jump1:     return frameJumpUp;
            Jump2:     return frameJumpDown;
            default:   return frameBlank;  // Idle and Hide draw nothing
        endcase
    endfunction

    // last-iteration flags for each phase
    assign loopLast     = loopCnt == (secondWalk ? 3'(`WALK_LOOPS_B-1) : 3'(`WALK_LOOPS_A-1));
    assign sniffLast    = sniffCnt == 3'(`SNIFF_ROUNDS-1);
    assign surpriseLast = surpriseCnt == 3'(`SURPRISE_TICKS-1);
    assign jumpLast     = jumpCnt == 3'(`JUMP_TICKS-1);

    // a dog can be relaunched only when not running
    assign launchOk = launch && ((state == Idle) || (state == Hide));

    always_comb
    begin
        nextState = state;
        moveX     = 1'b0;
        moveUp    = 1'b0;
        moveDown  = 1'b0;
        if (launchOk)
            nextState = Walk1;
        else if (frameTick)
        begin
            case (state)
                Walk1:     begin nextState = Walk2; moveX = 1'b1; end
                Walk2:     begin nextState = Walk3; moveX = 1'b1; end
                Walk3:     begin nextState = Walk4; moveX = 1'b1; end
                Walk4:
                begin
                    moveX = 1'b1;  // step taken in the state being left
                    if (!loopLast)
                        nextState = Walk1;
                    else
                        nextState = secondWalk ? Surprised : Sniff1;
                end
                Sniff1:    nextState = Sniff2;
                Sniff2:    nextState = sniffLast ? Walk1 : Sniff1;
                Surprised: nextState = surpriseLast ? Jump1 : Surprised;
                Jump1:
                begin
                    moveX  = 1'b1;
                    moveUp = 1'b1;    // rising half
                    nextState = jumpLast ? Jump2 : Jump1;
                end
                Jump2:
                begin
                    moveX    = 1'b1;
                    moveDown = 1'b1;  // falling back behind the grass
                    nextState = jumpLast ? Hide : Jump2;
                end
                default:   nextState = state;  // Idle, Hide wait for launch
            endcase
        end
    end

    always_ff @(posedge ANIM_Clk)
    begin
        if (reset)
        begin
            state       <= Idle;
            dogX        <= pixelCoordT'(`START_X);
            dogY        <= pixelCoordT'(`START_Y);
            frame       <= frameBlank;
            active      <= 1'b0;
            done        <= 1'b0;
            loopCnt     <= '0;
            sniffCnt    <= '0;
            surpriseCnt <= '0;
            jumpCnt     <= '0;
            secondWalk  <= 1'b0;
        end
        else
        begin
            state  <= nextState;
            frame  <= frameOf(nextState);  // outputs follow the state one cycle late
            active <= (nextState != Idle) && (nextState != Hide);
            done   <= nextState == Hide;
            if (launchOk)
            begin
                dogX        <= pixelCoordT'(`START_X);  // back to the start
                dogY        <= pixelCoordT'(`START_Y);
                loopCnt     <= '0;
                sniffCnt    <= '0;
                surpriseCnt <= '0;
                jumpCnt     <= '0;
                secondWalk  <= 1'b0;
            end
            else if (frameTick)
            begin
                if (moveX)
                    dogX <= dogX + pixelCoordT'(`STEP_X);
                if (moveUp)
                    dogY <= dogY - pixelCoordT'(`JUMP_STEP_Y);  // screen y grows down
                if (moveDown)
                    dogY <= dogY + pixelCoordT'(`JUMP_STEP_Y);
                case (state)
                    Walk4:     loopCnt <= loopLast ? 3'd0 : loopCnt + 3'd1;
                    Sniff2:
                    begin
                        sniffCnt <= sniffLast ? 3'd0 : sniffCnt + 3'd1;
                        if (sniffLast)
                            secondWalk <= 1'b1;
                    end
                    Surprised: surpriseCnt <= surpriseLast ? 3'd0 : surpriseCnt + 3'd1;
                    Jump1,
                    Jump2:     jumpCnt <= jumpLast ? 3'd0 : jumpCnt + 3'd1;
                    default:   ;
                endcase
            end
        end
    end

endmodule

//--- hdl/dogLauncher.sv
`timescale 1ns/1ps
`include "anim_settings.svh"

module dogLauncher import dogAnimPkg::*;
(
    input  logic                 ANIM_Clk,
    input  logic                 reset,
    input  logic                 go,
    input  logic                 frameTick,
    input  logic                 allDone,
    output logic [`NUM_DOGS-1:0] launch,
    output logic                 busy
);

    logic       launching;  // some dogs still waiting for their release
    dogIdxT     dogCnt;     // next dog to release
    logic [3:0] gapCnt;     // ticks to skip before that release
    logic       fireNow;    // release in this cycle

    // launch coincides with the frame tick itself
    assign fireNow = launching && frameTick && (gapCnt == '0);
    assign launch  = fireNow ? ({{(`NUM_DOGS-1){1'b0}}, 1'b1} << dogCnt) : '0;

    always_ff @(posedge ANIM_Clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            launching <= 1'b0;
            dogCnt    <= '0;
            gapCnt    <= '0;
        end
        else if (!busy)
        begin
            if (go)  // accept go only when idle
            begin
                busy      <= 1'b1;
                launching <= 1'b1;
                dogCnt    <= '0;
                gapCnt    <= '0;  // first tick after go releases dog 0
            end
        end
        else if (launching)
        begin
            if (fireNow)
            begin
                if (dogCnt == dogIdxT'(`NUM_DOGS-1))
                    launching <= 1'b0;  // last dog out
                else
                begin
                    dogCnt <= dogCnt + 2'd1;
                    gapCnt <= 4'(`LAUNCH_GAP-1);
                end
            end
            else if (frameTick)
                gapCnt <= gapCnt - 4'd1;  // count down the gap
        end
        else if (allDone)
            busy <= 1'b0;  // every dog hidden, re-arm
    end

endmodule

//--- hdl/dogScene.sv
`timescale 1ns/1ps
`include "anim_settings.svh"

module dogScene import screenPkg::*, dogAnimPkg::*;
(
    input  logic       ANIM_Clk,
    input  logic       reset,
    input  logic       go,
    input  logic       frameTick,
    input  pixelCoordT drawX,
    input  pixelCoordT drawY,
    output logic       hit,
    output dogIdxT     hitDog,
    output frameCodeT  hitFrame,
    output spriteOffT  offX,
    output spriteOffT  offY,
    output logic       busy,
    output logic       allDone
);

    logic       [`NUM_DOGS-1:0] launch;   // one-cycle start per dog
    pixelCoordT [`NUM_DOGS-1:0] dogXs;
    pixelCoordT [`NUM_DOGS-1:0] dogYs;
    frameCodeT  [`NUM_DOGS-1:0] frames;
    logic       [`NUM_DOGS-1:0] actives;  // dog currently drawn
    logic       [`NUM_DOGS-1:0] dones;    // dog reached Hide

    assign allDone = &dones;  // drops as soon as dog 0 is relaunched

    dogLauncher u_launcher (
        .ANIM_Clk  (ANIM_Clk),
        .reset     (reset),
        .go        (go),
        .frameTick (frameTick),
        .allDone   (allDone),
        .launch    (launch),
        .busy      (busy)
    );

    // one identical controller per dog
    for (genvar g = 0; g < `NUM_DOGS; g++)
    begin : genDog
        dogControl u_dog (
            .ANIM_Clk  (ANIM_Clk),
            .reset     (reset),
            .frameTick (frameTick),
            .launch    (launch[g]),
            .dogX      (dogXs[g]),
            .dogY      (dogYs[g]),
            .frame     (frames[g]),
            .active    (actives[g]),
            .done      (dones[g])
        );
    end

    dogSpriteSelect u_select (
        .ANIM_Clk (ANIM_Clk),
        .reset    (reset),
        .drawX    (drawX),
        .drawY    (drawY),
        .dogXs    (dogXs),
        .dogYs    (dogYs),
        .frames   (frames),
        .actives  (actives),
        .hit      (hit),
        .hitDog   (hitDog),
        .hitFrame (hitFrame),
        .offX     (offX),
        .offY     (offY)
    );

endmodule

//--- hdl/dogSpriteSelect.sv
`timescale 1ns/1ps
`include "anim_settings.svh"

module dogSpriteSelect import screenPkg::*, dogAnimPkg::*;
(
    input  logic                             ANIM_Clk,
    input  logic                             reset,
    input  pixelCoordT                       drawX,
    input  pixelCoordT                       drawY,
    input  pixelCoordT [`NUM_DOGS-1:0]       dogXs,
    input  pixelCoordT [`NUM_DOGS-1:0]       dogYs,
    input  frameCodeT  [`NUM_DOGS-1:0]       frames,
    input  logic       [`NUM_DOGS-1:0]       actives,
    output logic                             hit,
    output dogIdxT                           hitDog,
    output frameCodeT                        hitFrame,
    output spriteOffT                        offX,
    output spriteOffT                        offY
);

    pixelCoordT diffX [`NUM_DOGS];  // pixel minus dog corner, per dog
    pixelCoordT diffY [`NUM_DOGS];
    logic       [`NUM_DOGS-1:0] inBox;
    logic       anyHit;
    dogIdxT     winIdx;

    // box test for every dog in parallel
    always_comb
    begin
        for (int i = 0; i < `NUM_DOGS; i++)
        begin
            diffX[i] = drawX - dogXs[i];  // wraps when left of the dog
            diffY[i] = drawY - dogYs[i];
            inBox[i] = actives[i]
                && (drawX >= dogXs[i]) && (diffX[i] < pixelCoordT'(`DOG_W))
                && (drawY >= dogYs[i]) && (diffY[i] < pixelCoordT'(`DOG_H));
        end
    end

    // priority encoder, lowest index wins
    always_comb
    begin
        anyHit = |inBox;
        winIdx = '0;
        for (int i = `NUM_DOGS-1; i >= 0; i--)
            if (inBox[i])
                winIdx = dogIdxT'(i);
    end

    always_ff @(posedge ANIM_Clk)
    begin
        if (reset)
            hit <= 1'b0;
        else
            hit <= anyHit;
    end

    // payload only, qualified by hit
    always_ff @(posedge ANIM_Clk)
    begin
        hitDog   <= winIdx;
        hitFrame <= frames[winIdx];
        offX     <= spriteOffT'(diffX[winIdx]);  // box fits 5 bits
        offY     <= spriteOffT'(diffY[winIdx]);
    end

endmodule

//--- hdl/screenPkg.sv
package screenPkg;

    // raster x or y position, 640x480 fits in 10 bits
    typedef logic [9:0] pixelCoordT;

    // pixel position relative to the sprite's top-left corner
    typedef logic [4:0] spriteOffT;

endpackage

//--- project.f
+incdir+hdl
hdl/screenPkg.sv
hdl/dogAnimPkg.sv
hdl/dogLauncher.sv
hdl/dogControl.sv
hdl/dogSpriteSelect.sv
hdl/dogScene.sv
verif/tbClock.sv
verif/tbDogScene.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --Wno-fatal --top-module tbDogScene -f project.f -o simv

obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- verif/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
    output logic ANIM_Clk,
    output logic reset
);

    initial
    begin
        ANIM_Clk = 1'b0;
        forever #50 ANIM_Clk = ~ANIM_Clk;  // 100 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge ANIM_Clk);  // four reset cycles
        @(negedge ANIM_Clk);
        reset = 1'b0;
    end

endmodule

//--- verif/tbDogScene.sv
`timescale 1ns/1ps
`include "anim_settings.svh"

module tbDogScene import screenPkg::*, dogAnimPkg::*;
();

    localparam int ROUTINE_TICKS = 4 * `WALK_LOOPS_A + 2 * `SNIFF_ROUNDS + 4 * `WALK_LOOPS_B
                                 + `SURPRISE_TICKS + 2 * `JUMP_TICKS;  // ticks until Hide
    // frame ticks from go until the last dog hides
    localparam int RUN_TICKS     = 1 + (`NUM_DOGS - 1) * `LAUNCH_GAP + ROUTINE_TICKS;
    localparam int TEST_CYCLES   = 8 + 2 * 4 * (RUN_TICKS + 2) + 24;  // reset test and two runs
    localparam int CYCLE_LIMIT   = TEST_CYCLES * 3 / 2;

    logic       ANIM_Clk;
    logic       reset;
    logic       go;
    logic       frameTick;
    pixelCoordT drawX;
    pixelCoordT drawY;
    logic       hit;
    dogIdxT     hitDog;
    frameCodeT  hitFrame;
    spriteOffT  offX;
    spriteOffT  offY;
    logic       busy;
    logic       allDone;

    // reference model state
    int   mBusy;
    int   mLaunching;
    int   mTicks;                 // frame ticks since go
    int   mStarted [`NUM_DOGS];
    int   mN [`NUM_DOGS];         // routine ticks since launch
    int   expHit, expDog, expFrame, expOffX, expOffY;
    int   tickPhase;
    int   cycles = 0;
    int   errorCount;
    logic [31:0] rngState;

    tbClock u_clk (
        .ANIM_Clk (ANIM_Clk),
        .reset    (reset)
    );

    dogScene u_dut (
        .ANIM_Clk  (ANIM_Clk),
        .reset     (reset),
        .go        (go),
        .frameTick (frameTick),
        .drawX     (drawX),
        .drawY     (drawY),
        .hit       (hit),
        .hitDog    (hitDog),
        .hitFrame  (hitFrame),
        .offX      (offX),
        .offY      (offY),
        .busy      (busy),
        .allDone   (allDone)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int nextRand();
        rngState = xorshift32(rngState);
        return int'(rngState & 32'h7fff_ffff);
    endfunction

    // position and frame from the tick count phase by phase
    function automatic int modelX(input int i);
        int n;
        n = mN[i];
        if (!mStarted[i] || n < 16)
            return `START_X + (mStarted[i] ? 4 * n : 0);
        if (n < 22)
            return `START_X + 64;                // sniffing in place
        if (n < 30)
            return `START_X + 64 + 4 * (n - 22);
        if (n < 32)
            return `START_X + 96;                // surprised
        if (n < ROUTINE_TICKS)
            return `START_X + 96 + 4 * (n - 32);   // both jump halves keep moving right
        return `START_X + 136;
    endfunction

    function automatic int modelY(input int i);
        int n;
        n = mN[i];
        if (!mStarted[i] || n < 32 || n >= ROUTINE_TICKS)
            return `START_Y;
        if (n < 37)
            return `START_Y - 6 * (n - 32);      // rising
        return `START_Y - 30 + 6 * (n - 37);     // falling
    endfunction

    function automatic int modelFrame(input int i);
        int n;
        n = mN[i];
        if (!mStarted[i] || n >= ROUTINE_TICKS)
            return 0;
        if (n < 16)
            return (n % 4) + 1;
        if (n < 22)
            return 5 + ((n - 16) % 2);
        if (n < 30)
            return ((n - 22) % 4) + 1;
        if (n < 32)
            return 7;
        return (n < 37) ? 8 : 9;
    endfunction

    function automatic int modelActive(input int i);
        return (mStarted[i] && mN[i] < ROUTINE_TICKS) ? 1 : 0;
    endfunction

    function automatic int modelDone(input int i);
        return (mStarted[i] && mN[i] >= ROUTINE_TICKS) ? 1 : 0;
    endfunction

    function automatic int modelAllDone();
        int d;
        d = 1;
        for (int i = 0; i < `NUM_DOGS; i++)
            d = d & modelDone(i);
        return d;
    endfunction

    task automatic checkEq(input int actual, input int expected, input string msg);
        if (actual != expected)
        begin
            errorCount++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, msg, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // lowest active index whose box holds the pixel
    task automatic predictSelect(input int px, input int py);
        expHit = 0;
        for (int i = `NUM_DOGS - 1; i >= 0; i--)
        begin
            if (modelActive(i) && px >= modelX(i) && px - modelX(i) < `DOG_W
                && py >= modelY(i) && py - modelY(i) < `DOG_H)
            begin
                expHit   = 1;
                expDog   = i;
                expFrame = modelFrame(i);
                expOffX  = px - modelX(i);
                expOffY  = py - modelY(i);
            end
        end
    endtask

    // one rising edge of the scene with the inputs driven this cycle
    task automatic advanceModel(input int g, input int t);
        int launchMask;
        int allD;
        launchMask = 0;
        allD       = modelAllDone();
        if (!mBusy)
        begin
            if (g)
            begin
                mBusy      = 1;
                mLaunching = 1;
                mTicks     = 0;
            end
        end
        else if (mLaunching)
        begin
            if (t)
            begin
                mTicks++;
                for (int i = 0; i < `NUM_DOGS; i++)
                    if (mTicks == 1 + i * `LAUNCH_GAP)
                        launchMask = launchMask | (1 << i);
                if (mTicks == 1 + (`NUM_DOGS - 1) * `LAUNCH_GAP)
                    mLaunching = 0;  // last dog released
            end
        end
        else if (allD)
            mBusy = 0;
        for (int i = 0; i < `NUM_DOGS; i++)
        begin
            if (launchMask[i] && (!mStarted[i] || mN[i] >= ROUTINE_TICKS))
            begin
                mStarted[i] = 1;
                mN[i]       = 0;
            end
            else if (t && mStarted[i] && mN[i] < ROUTINE_TICKS)
                mN[i]++;
        end
    endtask

    // check last cycle's response and then drive the next inputs on the falling edge
    task automatic stepCycle(input int goIn, input int px, input int py);
        @(negedge ANIM_Clk);
        checkEq(hit, expHit, "hit");
        if (expHit)
        begin
            checkEq(hitDog, expDog, "hitDog");
            checkEq(hitFrame, expFrame, "hitFrame");
            checkEq(offX, expOffX, "offX");
            checkEq(offY, expOffY, "offY");
        end
        checkEq(busy, mBusy, "busy");
        checkEq(allDone, modelAllDone(), "allDone");
        tickPhase = (tickPhase + 1) % 4;
        frameTick = (tickPhase == 0);  // one tick every 4 cycles
        go        = goIn[0];
        drawX     = pixelCoordT'(px);
        drawY     = pixelCoordT'(py);
        predictSelect(px, py);
        advanceModel(goIn, tickPhase == 0);
    endtask

    task automatic randomProbe(input int goIn);
        int px;
        int py;
        px = 3 + nextRand() % 170;
        py = 270 + nextRand() % 80;
        stepCycle(goIn, px, py);
    endtask

    task automatic testAfterReset();
        for (int k = 0; k < 8; k++)
            stepCycle(0, `START_X, `START_Y);  // no dog active yet
        checkEq(busy, 0, "busy after reset");
        checkEq(allDone, 0, "allDone after reset");
    endtask

    task automatic testLaunchOrder();
        stepCycle(1, `START_X, `START_Y);
        while (!hit)
            stepCycle(0, `START_X, `START_Y);
        checkEq(hitDog, 0, "first visible dog");  // dog 0 at its start corner
        checkEq(hitFrame, 1, "first frame");
        checkEq(offX, 0, "first offX");
        checkEq(offY, 0, "first offY");
        while (mTicks < 1 + (`NUM_DOGS - 1) * `LAUNCH_GAP)
            stepCycle(0, `START_X, `START_Y);
    endtask

    task automatic testDogZeroRoutine();
        while (!modelDone(0))
        begin
            stepCycle(0, modelX(0), modelY(0));          // top-left corner
            stepCycle(0, modelX(0) - 1, modelY(0) - 1);  // just outside it
        end
    endtask

    task automatic testRandomProbes();
        for (int k = 0; k < 24; k++)
            randomProbe(0);  // dogs 1 to 3 still running and overlapping
    endtask

    task automatic testBusyAndFinish();
        checkEq(busy, 1, "busy before the extra go");
        stepCycle(1, `START_X, `START_Y);  // ignored while busy
        while (!allDone)
            randomProbe(0);
        while (busy)
            randomProbe(0);
        for (int k = 0; k < 12; k++)
            randomProbe(0);  // hidden dogs are never hit
        checkEq(busy, 0, "busy after allDone");
    endtask

    task automatic testRestart();
        stepCycle(1, `START_X, `START_Y);
        while (mLaunching)
            stepCycle(0, `START_X, `START_Y);  // each dog shows up at the start again
        while (!modelDone(0))
        begin
            stepCycle(0, modelX(0), modelY(0));
            randomProbe(0);
        end
        while (!allDone)
            randomProbe(0);
        while (busy)
            randomProbe(0);
    endtask

    always @(posedge ANIM_Clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        go         = 1'b0;
        frameTick  = 1'b0;
        drawX      = '0;
        drawY      = '0;
        mBusy      = 0;
        mLaunching = 0;
        mTicks     = 0;
        expHit     = 0;
        expDog     = 0;
        expFrame   = 0;
        expOffX    = 0;
        expOffY    = 0;
        tickPhase  = 0;
        errorCount = 0;
        rngState   = 32'd4814;
        for (int i = 0; i < `NUM_DOGS; i++)
        begin
            mStarted[i] = 0;
            mN[i]       = 0;
        end
        wait (reset === 1'b0);
        testAfterReset();
        testLaunchOrder();
        testDogZeroRoutine();
        testRandomProbes();
        testBusyAndFinish();
        testRestart();
        if (errorCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
